// File: testbench/div_stim.txt
# Columns: op dividend divisor expected, all hexadecimal
# op: 0 signed quotient, 1 unsigned quotient, 2 signed remainder, 3 unsigned remainder
# Unsigned, dividend below divisor
1 00000005 00000007 00000000
3 00000005 00000007 00000005
# Unsigned, equal operands
1 12345678 12345678 00000001
3 12345678 12345678 00000000
# Unsigned, divisor of one
1 9abcdef0 00000001 9abcdef0
3 9abcdef0 00000001 00000000
1 ffffffff 00000001 ffffffff
3 ffffffff 00000001 00000000
# Unsigned, general cases
1 00000064 00000007 0000000e
3 00000064 00000007 00000002
1 ffffffff 00010000 0000ffff
3 ffffffff 00010000 0000ffff
1 80000000 ffffffff 00000000
3 80000000 ffffffff 80000000
# Signed, all four sign combinations of 7 and 2
0 00000007 00000002 00000003
2 00000007 00000002 00000001
0 fffffff9 00000002 fffffffd
2 fffffff9 00000002 ffffffff
0 00000007 fffffffe fffffffd
2 00000007 fffffffe 00000001
0 fffffff9 fffffffe 00000003
2 fffffff9 fffffffe ffffffff
0 80000000 00000001 80000000
# Zero divisor
0 00001234 00000000 ffffffff
1 00001234 00000000 ffffffff
2 80000005 00000000 80000005
3 80000005 00000000 80000005
# Signed overflow
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000

// File: filelist.f
hdl/div_pkg.sv
hdl/div_operand_prep.sv
hdl/div_core.sv
hdl/div_result_fix.sv
hdl/div_ctrl.sv
hdl/div_unit.sv
testbench/tb_div_unit.sv

// File: Makefile
# Verilator build and run for the divide unit testbench
TOOL      ?= verilator
FLAGS     ?= --binary --timing
TOP       := tb_div_unit
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := TB FAILED
PASS_MSG  := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_div_unit.sv
//////////////////////////////////////////////////////////////////////
// Testbench for div_unit. Run from the project root so that the file
// testbench/div_stim.txt is found. Random cases use a fixed seed.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_div_unit;
    import div_pkg::*;

    localparam int ack_timeout     = 100;
    localparam int release_timeout = 10;
    localparam int random_cases    = 200;
    localparam int hold_cycles     = 5;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req;
    div_op_t           op;
    logic [data_w-1:0] dividend;
    logic [data_w-1:0] divisor;
    logic              ack;
    logic [data_w-1:0] result;

    logic [31:0]       lfsr_state;
    int                checks;
    int                errors;
    int                tests_run;
    int                tests_failed;

    div_unit i_div_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .ack      (ack),
        .result   (result)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // RISC-V results: zero divisor and signed overflow are fixed values,
    // otherwise the quotient truncates toward zero
    function automatic logic [data_w-1:0] expected_result(input div_op_t o,
            input logic [data_w-1:0] a, input logic [data_w-1:0] b);
        logic [data_w-1:0] q;
        logic [data_w-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (!o[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = '0;
        end else if (o[0]) begin
            q = a / b;
            r = a % b;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        return o[1] ? r : q;
    endfunction

    // Inputs change and outputs are sampled 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic run_division(input div_op_t o, input logic [data_w-1:0] a,
            input logic [data_w-1:0] b, input logic [data_w-1:0] expv, input int hold);
        int cnt;
        req      = 1'b1;
        op       = o;
        dividend = a;
        divisor  = b;
        cnt = 0;
        tick();
        while (ack !== 1'b1 && cnt < ack_timeout) begin
            tick();
            cnt++;
        end
        if (ack !== 1'b1) begin
            abort_run("Timeout while waiting for ack to rise after req");
        end else begin
            checks++;
            if (result !== expv) begin
                $display("ERROR at %0t: %s %h by %h expected %h actual %h",
                         $time, o.name(), a, b, expv, result);
                errors++;
            end
            // Requester keeps req high, so ack and result must hold
            for (int i = 0; i < hold; i++) begin
                tick();
                checks++;
                if (ack !== 1'b1 || result !== expv) begin
                    $display("ERROR at %0t: req held, expected %h, actual ack %b result %h",
                             $time, expv, ack, result);
                    errors++;
                end
            end
            req = 1'b0;
            cnt = 0;
            tick();
            while (ack !== 1'b0 && cnt < release_timeout) begin
                tick();
                cnt++;
            end
            if (ack !== 1'b0) begin
                abort_run("Timeout while waiting for ack to fall after req dropped");
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errs_before);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    initial begin
        int                fd;
        int                base;
        int                cases;
        string             line;
        logic [1:0]        op_bits;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] expv;
        logic [31:0]       bits;
        rst_n        = 1'b0;
        req          = 1'b0;
        op           = op_div;
        dividend     = '0;
        divisor      = '0;
        lfsr_state   = 32'd96;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) tick();
        rst_n = 1'b1;

        base = errors;
        tick();
        checks++;
        if (ack !== 1'b0) begin
            $display("ERROR at %0t: expected ack 0 after reset, actual %b", $time, ack);
            errors++;
        end
        report_test("reset", base);

        base  = errors;
        cases = 0;
        fd = $fopen("testbench/div_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file testbench/div_stim.txt");
        end else begin
            // Comment and blank lines do not scan as four hex fields
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h", op_bits, a, b, expv) == 4) begin
                    run_division(div_op_t'(op_bits), a, b, expv, 0);
                    cases++;
                end
            end
            $fclose(fd);
            checks++;
            if (cases == 0) begin
                $display("No cases could be read from the stimulus file");
                errors++;
            end
            report_test($sformatf("stimulus file (%0d cases)", cases), base);
        end

        base = errors;
        run_division(op_divu, 32'd100, 32'd7, expected_result(op_divu, 32'd100, 32'd7),
                     hold_cycles);
        report_test("handshake hold", base);

        base = errors;
        for (int i = 0; i < random_cases; i++) begin
            draw_bits(2, bits);
            op_bits = bits[1:0];
            draw_bits(32, a);
            draw_bits(32, b);
            // A random shift spreads the quotient sizes
            draw_bits(5, bits);
            b = b >> bits[4:0];
            run_division(div_op_t'(op_bits), a, b,
                         expected_result(div_op_t'(op_bits), a, b), 0);
        end
        report_test($sformatf("random (%0d cases)", random_cases), base);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/div_unit.sv
//////////////////////////////////////////////////////////////////////
// 32-bit divide unit, one division in flight at a time.
// Operands must stay stable from req high until ack is seen.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module div_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  div_pkg::div_op_t           op,
    input  logic [div_pkg::data_w-1:0] dividend,
    input  logic [div_pkg::data_w-1:0] divisor,
    output logic                       ack,
    output logic [div_pkg::data_w-1:0] result
);
    import div_pkg::*;

    logic              load;
    logic              start;
    logic              take_core;
    logic              take_special;
    logic              done;
    logic              special;
    logic              neg_q;
    logic              neg_r;
    logic              rem_sel;
    logic [data_w-1:0] mag_a;
    logic [data_w-1:0] mag_b;
    logic [data_w-1:0] special_result;
    logic [data_w-1:0] quotient;
    logic [data_w-1:0] remainder;

    div_ctrl i_div_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .special      (special),
        .done         (done),
        .ack          (ack),
        .load         (load),
        .start        (start),
        .take_core    (take_core),
        .take_special (take_special)
    );

    div_operand_prep i_div_operand_prep (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .op             (op),
        .dividend       (dividend),
        .divisor        (divisor),
        .mag_a          (mag_a),
        .mag_b          (mag_b),
        .neg_q          (neg_q),
        .neg_r          (neg_r),
        .rem_sel        (rem_sel),
        .special        (special),
        .special_result (special_result)
    );

    div_core i_div_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dividend  (mag_a),
        .divisor   (mag_b),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_result_fix i_div_result_fix (
        .clk            (clk),
        .rst_n          (rst_n),
        .take_core      (take_core),
        .take_special   (take_special),
        .quotient       (quotient),
        .remainder      (remainder),
        .neg_q          (neg_q),
        .neg_r          (neg_r),
        .rem_sel        (rem_sel),
        .special_result (special_result),
        .result         (result)
    );

endmodule

// File: hdl/div_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Four-phase req/ack sequencer. All strobes are one-cycle pulses and
// ack stays high for as long as the requester holds req.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module div_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic special,
    input  logic done,
    output logic ack,
    output logic load,
    output logic start,
    output logic take_core,
    output logic take_special
);

    typedef enum logic [2:0] {
        st_idle,
        st_prep,
        st_run,
        st_fix,
        st_hold,
        st_release
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req) begin
                    state_next = st_prep;
                end
            end
            st_prep: begin
                state_next = special ? st_fix : st_run;
            end
            st_run: begin
                if (done) begin
                    state_next = st_fix;
                end
            end
            st_fix: begin
                state_next = st_hold;
            end
            st_hold: begin
                if (!req) begin
                    state_next = st_release;
                end
            end
            st_release: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    assign load         = (state == st_idle) & req;
    assign start        = (state == st_prep) & ~special;
    assign take_special = (state == st_prep) & special;
    assign take_core    = (state == st_run) & done;
    assign ack          = (state == st_hold);

endmodule

// File: hdl/div_result_fix.sv
//////////////////////////////////////////////////////////////////////
// Result register. Sign flags are already clear for unsigned ops.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module div_result_fix (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       take_core,
    input  logic                       take_special,
    input  logic [div_pkg::data_w-1:0] quotient,
    input  logic [div_pkg::data_w-1:0] remainder,
    input  logic                       neg_q,
    input  logic                       neg_r,
    input  logic                       rem_sel,
    input  logic [div_pkg::data_w-1:0] special_result,
    output logic [div_pkg::data_w-1:0] result
);
    import div_pkg::*;

    logic [data_w-1:0] q_signed;
    logic [data_w-1:0] r_signed;

    // Quotient truncates toward zero, remainder follows the dividend
    assign q_signed = neg_q ? -quotient : quotient;
    assign r_signed = neg_r ? -remainder : remainder;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (take_core) begin
            result <= rem_sel ? r_signed : q_signed;
        end else if (take_special) begin
            result <= special_result;
        end
    end

endmodule

// File: hdl/div_core.sv
//////////////////////////////////////////////////////////////////////
// Unsigned divider, one subtraction of the largest fitting shift per
// cycle. The divisor must be nonzero or the core never finishes.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module div_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [div_pkg::data_w-1:0] dividend,
    input  logic [div_pkg::data_w-1:0] divisor,
    output logic                       done,
    output logic [div_pkg::data_w-1:0] quotient,
    output logic [div_pkg::data_w-1:0] remainder
);
    import div_pkg::*;

    // Working remainder carries one spare bit above the data word
    logic [data_w:0]     work;
    logic [data_w-1:0]   dvsr;
    logic                busy;

    logic [2*data_w-1:0] wide_work;
    logic [data_w-1:0]   fits;
    logic [shift_w-1:0]  idx;
    logic [data_w:0]     sub_val;
    logic [data_w-1:0]   bit_val;

    assign wide_work = {{(data_w-1){1'b0}}, work};

    // Compare in double width so a shifted divisor cannot wrap around
    genvar i;
    generate
        for (i = 0; i < data_w; i++) begin : g_fit
            assign fits[i] = (({{data_w{1'b0}}, dvsr} << i) <= wide_work);
        end
    endgenerate

    // The fit vector is monotone, so the highest set bit is the
    // largest shift that still fits
    always_comb begin
        idx = '0;
        for (int k = 0; k < data_w; k++) begin
            if (fits[k]) begin
                idx = shift_w'(k);
            end
        end
    end

    assign sub_val = {1'b0, dvsr} << idx;
    assign bit_val = {{(data_w-1){1'b0}}, 1'b1} << idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && !fits[0]) begin
                // Working remainder is below the divisor
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            work     <= {1'b0, dividend};
            dvsr     <= divisor;
            quotient <= '0;
        end else if (busy) begin
            if (fits[0]) begin
                work     <= work - sub_val;
                quotient <= quotient | bit_val;
            end else begin
                remainder <= work[data_w-1:0];
            end
        end
    end

endmodule

// File: hdl/div_operand_prep.sv
//////////////////////////////////////////////////////////////////////
// Captures operands on load and turns signed ones into magnitudes.
// Zero divisor and signed overflow get their RISC-V result here.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module div_operand_prep (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  div_pkg::div_op_t           op,
    input  logic [div_pkg::data_w-1:0] dividend,
    input  logic [div_pkg::data_w-1:0] divisor,
    output logic [div_pkg::data_w-1:0] mag_a,
    output logic [div_pkg::data_w-1:0] mag_b,
    output logic                       neg_q,
    output logic                       neg_r,
    output logic                       rem_sel,
    output logic                       special,
    output logic [div_pkg::data_w-1:0] special_result
);
    import div_pkg::*;

    logic signed_op;
    logic a_neg;
    logic b_neg;
    logic div_zero;
    logic overflow;

    assign signed_op = ~op[0];
    assign a_neg     = signed_op & dividend[data_w-1];
    assign b_neg     = signed_op & divisor[data_w-1];
    assign div_zero  = (divisor == '0);
    assign overflow  = signed_op & (dividend == min_neg) & (divisor == '1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            neg_q   <= 1'b0;
            neg_r   <= 1'b0;
            rem_sel <= 1'b0;
            special <= 1'b0;
        end else if (load) begin
            neg_q   <= a_neg ^ b_neg;
            neg_r   <= a_neg;
            rem_sel <= op[1];
            special <= div_zero | overflow;
        end
    end

    // Negating the most negative value leaves 2^31, which is its magnitude
    always_ff @(posedge clk) begin
        if (load) begin
            mag_a <= a_neg ? -dividend : dividend;
            mag_b <= b_neg ? -divisor : divisor;
            if (div_zero) begin
                special_result <= op[1] ? dividend : '1;
            end else if (overflow) begin
                special_result <= op[1] ? '0 : dividend;
            end else begin
                special_result <= '0;
            end
        end
    end

endmodule

// File: hdl/div_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths and operation codes for the 32-bit divide unit.
// Bit 1 of the operation code selects the remainder, bit 0 unsigned.
//////////////////////////////////////////////////////////////////////

package div_pkg;

    // Operand and result width
    localparam int data_w = 32;

    // Width of a shift amount inside the divider core
    localparam int shift_w = 5;

    // Most negative signed operand, used for the overflow case
    localparam logic [data_w-1:0] min_neg = {1'b1, {(data_w-1){1'b0}}};

    // Operation code as seen on the outside op port
    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_t;

endpackage
